// ==== hw/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	// slot layout, channel-major
	localparam int NUM_CH    = 6;
	localparam int NUM_OP    = 4;
	localparam int NUM_SLOTS = NUM_CH * NUM_OP;

	// clock-enable divide ratios, N6 after reset
	localparam int DIV_N6 = 6;
	localparam int DIV_N3 = 3;
	localparam int DIV_N2 = 2;

	// global registers
	localparam logic [7:0] ADDR_TMRA_HI = 8'h24;
	localparam logic [7:0] ADDR_TMRA_LO = 8'h25;
	localparam logic [7:0] ADDR_TMRB    = 8'h26;
	// bits 5..0: clr b, clr a, en b, en a, load b, load a
	localparam logic [7:0] ADDR_TMR_CTL = 8'h27;
	localparam logic [7:0] ADDR_KEYON   = 8'h28;
	localparam logic [7:0] ADDR_DIV6    = 8'h2D;
	localparam logic [7:0] ADDR_DIV3    = 8'h2E;
	localparam logic [7:0] ADDR_DIV2    = 8'h2F;

	// operator bases: dt1 3b / mul 4b, tl 7b, ks 2b / ar 5b
	localparam logic [7:0] ADDR_DT1_MUL = 8'h30;
	localparam logic [7:0] ADDR_TL      = 8'h40;
	localparam logic [7:0] ADDR_KS_AR   = 8'h50;

	// channel bases: fnum 11b, block 3b, fb 3b, alg 3b
	localparam logic [7:0] ADDR_FNUM_LO = 8'hA0;
	localparam logic [7:0] ADDR_BLK_FHI = 8'hA4;
	localparam logic [7:0] ADDR_FB_ALG  = 8'hB0;

	// timer A is 10 bits, timer B 8 bits
	typedef enum logic [2:0] {
		UPD_DT1_MUL,
		UPD_TL,
		UPD_KS_AR,
		UPD_FNUM_LO,
		UPD_BLK_FHI,
		UPD_FB_ALG,
		UPD_KEYON
	} fm_upd_e;

endpackage

`default_nettype wire

// ==== hw/fm_upd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pending slot update, valid holds until done
interface fm_upd_if
	import fm_pkg::*;
();
	logic       valid;
	fm_upd_e    kind;
	logic [2:0] ch;
	logic [1:0] op;
	// key-on mask in bits 7..4
	logic [7:0] data;
	logic       done;

	modport src (output valid, kind, ch, op, data, input done);
	modport dst (input valid, kind, ch, op, data, output done);

endinterface

`default_nettype wire

// ==== hw/fm_tmr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fm_tmr_if ();
	logic [9:0] value_a;
	logic [7:0] value_b;
	logic       load_a;
	logic       load_b;
	logic       en_a;
	logic       en_b;
	// one-cycle flag clears
	logic       clr_a;
	logic       clr_b;

	modport ctl (output value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b);
	modport tmr (input value_a, value_b, load_a, load_b, en_a, en_b, clr_a, clr_b);

endinterface

`default_nettype wire

// ==== hw/fm_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_mmr
	import fm_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic       busy,
	output logic       clk_en,
	fm_upd_if.src      upd,
	fm_tmr_if.ctl      tmr
);

	logic [7:0] sel_reg;
	logic       bank;
	logic [2:0] div_cnt;
	logic [2:0] div_n;
	logic [2:0] div_next;
	logic       data_wr;
	logic       slot_req;
	fm_upd_e    req_kind;
	logic       req_bank;
	logic [1:0] low_ch;
	logic [2:0] req_ch;

	// data port writes are dropped while a previous one is in flight
	assign data_wr = wr && addr[0] && !busy;

	// slot register decode
	always_comb begin
		slot_req = 1'b0;
		req_kind = UPD_DT1_MUL;
		req_bank = bank;
		low_ch   = sel_reg[1:0];
		if (sel_reg == ADDR_KEYON) begin
			slot_req = 1'b1;
			req_kind = UPD_KEYON;
			req_bank = din[2];
			low_ch   = din[1:0];
		end else if (sel_reg[7:4] == ADDR_DT1_MUL[7:4]) begin
			slot_req = 1'b1;
			req_kind = UPD_DT1_MUL;
		end else if (sel_reg[7:4] == ADDR_TL[7:4]) begin
			slot_req = 1'b1;
			req_kind = UPD_TL;
		end else if (sel_reg[7:4] == ADDR_KS_AR[7:4]) begin
			slot_req = 1'b1;
			req_kind = UPD_KS_AR;
		end else if (sel_reg[7:2] == ADDR_FNUM_LO[7:2]) begin
			slot_req = 1'b1;
			req_kind = UPD_FNUM_LO;
		end else if (sel_reg[7:2] == ADDR_BLK_FHI[7:2]) begin
			slot_req = 1'b1;
			req_kind = UPD_BLK_FHI;
		end else if (sel_reg[7:2] == ADDR_FB_ALG[7:2]) begin
			slot_req = 1'b1;
			req_kind = UPD_FB_ALG;
		end
		// channel 3 of a bank does not exist
		if (low_ch == 2'd3) begin
			slot_req = 1'b0;
		end
		req_ch = req_bank ? (3'd3 + {1'b0, low_ch}) : {1'b0, low_ch};
	end

	// clock-enable divider, new ratio taken at wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= 3'd0;
			div_n   <= 3'(DIV_N6);
			clk_en  <= 1'b0;
		end else begin
			clk_en <= (div_cnt == div_n - 3'd1);
			if (div_cnt == div_n - 3'd1) begin
				div_cnt <= 3'd0;
				div_n   <= div_next;
			end else begin
				div_cnt <= div_cnt + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg     <= 8'h00;
			bank        <= 1'b0;
			busy        <= 1'b0;
			upd.valid   <= 1'b0;
			div_next    <= 3'(DIV_N6);
			tmr.value_a <= 10'd0;
			tmr.value_b <= 8'd0;
			tmr.load_a  <= 1'b0;
			tmr.load_b  <= 1'b0;
			tmr.en_a    <= 1'b0;
			tmr.en_b    <= 1'b0;
			tmr.clr_a   <= 1'b0;
			tmr.clr_b   <= 1'b0;
		end else begin
			tmr.clr_a <= 1'b0;
			tmr.clr_b <= 1'b0;
			// busy tracks the request and drops with valid
			busy <= upd.valid && !upd.done;
			if (upd.valid && upd.done) begin
				upd.valid <= 1'b0;
			end
			if (wr && !addr[0]) begin
				sel_reg <= din;
				bank    <= addr[1];
			end
			if (data_wr) begin
				busy <= 1'b1;
				if (slot_req) begin
					upd.valid <= 1'b1;
				end
				case (sel_reg)
					ADDR_TMRA_HI: tmr.value_a[9:2] <= din;
					ADDR_TMRA_LO: tmr.value_a[1:0] <= din[1:0];
					ADDR_TMRB:    tmr.value_b <= din;
					ADDR_TMR_CTL: begin
						{tmr.clr_b, tmr.clr_a} <= din[5:4];
						{tmr.en_b, tmr.en_a} <= din[3:2];
						{tmr.load_b, tmr.load_a} <= din[1:0];
					end
					ADDR_DIV6:    div_next <= 3'(DIV_N6);
					ADDR_DIV3:    div_next <= 3'(DIV_N3);
					ADDR_DIV2:    div_next <= 3'(DIV_N2);
					default: ;
				endcase
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (data_wr && slot_req) begin
			upd.kind <= req_kind;
			upd.ch   <= req_ch;
			upd.op   <= sel_reg[3:2];
			upd.data <= din;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fm_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_reg_file
	import fm_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        clk_en,
	fm_upd_if.dst       upd,
	output logic        slot_valid,
	output logic [2:0]  slot_ch,
	output logic [1:0]  slot_op,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output logic [2:0]  alg,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic        keyon
);

	// per-slot operator fields
	logic [2:0]  dt1_q [NUM_SLOTS];
	logic [3:0]  mul_q [NUM_SLOTS];
	logic [6:0]  tl_q  [NUM_SLOTS];
	logic [1:0]  ks_q  [NUM_SLOTS];
	logic [4:0]  ar_q  [NUM_SLOTS];
	logic        kon_q [NUM_SLOTS];
	// per-channel fields
	logic [10:0] fnum_q  [NUM_CH];
	logic [2:0]  block_q [NUM_CH];
	logic [2:0]  fb_q    [NUM_CH];
	logic [2:0]  alg_q   [NUM_CH];

	logic [2:0]  cur_ch;
	logic [1:0]  cur_op;
	logic [4:0]  cur_slot;
	logic        apply;
	logic [2:0]  nxt_dt1;
	logic [3:0]  nxt_mul;
	logic [6:0]  nxt_tl;
	logic [1:0]  nxt_ks;
	logic [4:0]  nxt_ar;
	logic        nxt_kon;
	logic [10:0] nxt_fnum;
	logic [2:0]  nxt_block;
	logic [2:0]  nxt_fb;
	logic [2:0]  nxt_alg;

	assign cur_slot = {cur_ch, cur_op};

	// operator kinds hit their slot, channel kinds hit operator 0
	always_comb begin
		case (upd.kind)
			UPD_DT1_MUL, UPD_TL, UPD_KS_AR:
				apply = upd.valid && (upd.ch == cur_ch) && (upd.op == cur_op);
			default:
				apply = upd.valid && (upd.ch == cur_ch) && (cur_op == 2'd0);
		endcase
	end

	assign upd.done = clk_en && apply;

	// current slot with any pending update merged in
	always_comb begin
		nxt_dt1   = dt1_q[cur_slot];
		nxt_mul   = mul_q[cur_slot];
		nxt_tl    = tl_q[cur_slot];
		nxt_ks    = ks_q[cur_slot];
		nxt_ar    = ar_q[cur_slot];
		nxt_kon   = kon_q[cur_slot];
		nxt_fnum  = fnum_q[cur_ch];
		nxt_block = block_q[cur_ch];
		nxt_fb    = fb_q[cur_ch];
		nxt_alg   = alg_q[cur_ch];
		if (apply) begin
			case (upd.kind)
				UPD_DT1_MUL: begin
					nxt_dt1 = upd.data[6:4];
					nxt_mul = upd.data[3:0];
				end
				UPD_TL:      nxt_tl = upd.data[6:0];
				UPD_KS_AR: begin
					nxt_ks = upd.data[7:6];
					nxt_ar = upd.data[4:0];
				end
				UPD_FNUM_LO: nxt_fnum[7:0] = upd.data;
				UPD_BLK_FHI: begin
					nxt_block      = upd.data[5:3];
					nxt_fnum[10:8] = upd.data[2:0];
				end
				UPD_FB_ALG: begin
					nxt_fb  = upd.data[5:3];
					nxt_alg = upd.data[2:0];
				end
				// scan sits on operator 0 here
				UPD_KEYON:   nxt_kon = upd.data[4];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_ch <= 3'd0;
			cur_op <= 2'd0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				dt1_q[i] <= '0;
				mul_q[i] <= '0;
				tl_q[i]  <= '0;
				ks_q[i]  <= '0;
				ar_q[i]  <= '0;
				kon_q[i] <= 1'b0;
			end
			for (int c = 0; c < NUM_CH; c++) begin
				fnum_q[c]  <= '0;
				block_q[c] <= '0;
				fb_q[c]    <= '0;
				alg_q[c]   <= '0;
			end
		end else if (clk_en) begin
			dt1_q[cur_slot]  <= nxt_dt1;
			mul_q[cur_slot]  <= nxt_mul;
			tl_q[cur_slot]   <= nxt_tl;
			ks_q[cur_slot]   <= nxt_ks;
			ar_q[cur_slot]   <= nxt_ar;
			fnum_q[cur_ch]   <= nxt_fnum;
			block_q[cur_ch]  <= nxt_block;
			fb_q[cur_ch]     <= nxt_fb;
			alg_q[cur_ch]    <= nxt_alg;
			if (apply && upd.kind == UPD_KEYON) begin
				// key-on mask covers all four operators of the channel
				for (int i = 0; i < NUM_OP; i++) begin
					kon_q[{cur_ch, 2'(i)}] <= upd.data[4 + i];
				end
			end else begin
				kon_q[cur_slot] <= nxt_kon;
			end
			cur_op <= cur_op + 2'd1;
			if (cur_op == 2'(NUM_OP - 1)) begin
				cur_ch <= (cur_ch == 3'(NUM_CH - 1)) ? 3'd0 : cur_ch + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else begin
			slot_valid <= clk_en;
		end
	end

	// stream payload
	always_ff @(posedge clk) begin
		if (clk_en) begin
			slot_ch <= cur_ch;
			slot_op <= cur_op;
			fnum    <= nxt_fnum;
			block   <= nxt_block;
			fb      <= nxt_fb;
			alg     <= nxt_alg;
			dt1     <= nxt_dt1;
			mul     <= nxt_mul;
			tl      <= nxt_tl;
			ks      <= nxt_ks;
			ar      <= nxt_ar;
			keyon   <= nxt_kon;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fm_timers.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_timers (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	fm_tmr_if.tmr      tmr,
	output logic       irq,
	output logic [1:0] status
);

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [3:0] pre_b;
	logic       load_a_q;
	logic       load_b_q;
	logic       run_a;
	logic       run_b;
	logic       ovf_a;
	logic       ovf_b;
	logic       flag_a;
	logic       flag_b;

	// count only after the load edge has set the counter
	assign run_a = tmr.load_a && load_a_q;
	assign run_b = tmr.load_b && load_b_q;
	assign ovf_a = clk_en && run_a && (cnt_a == 10'h3ff);
	// timer B steps once per 16 ticks
	assign ovf_b = clk_en && run_b && (pre_b == 4'hf) && (cnt_b == 8'hff);

	always_ff @(posedge clk) begin
		if (rst) begin
			load_a_q <= 1'b0;
			load_b_q <= 1'b0;
			cnt_a    <= 10'd0;
			cnt_b    <= 8'd0;
			pre_b    <= 4'd0;
		end else begin
			load_a_q <= tmr.load_a;
			load_b_q <= tmr.load_b;
			if ((tmr.load_a && !load_a_q) || ovf_a) begin
				cnt_a <= tmr.value_a;
			end else if (clk_en && run_a) begin
				cnt_a <= cnt_a + 10'd1;
			end
			if (tmr.load_b && !load_b_q) begin
				cnt_b <= tmr.value_b;
				pre_b <= 4'd0;
			end else if (clk_en && run_b) begin
				pre_b <= pre_b + 4'd1;
				if (ovf_b) begin
					cnt_b <= tmr.value_b;
				end else if (pre_b == 4'hf) begin
					cnt_b <= cnt_b + 8'd1;
				end
			end
		end
	end

	// a clear wins over a coincident overflow
	always_ff @(posedge clk) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (tmr.clr_a) begin
				flag_a <= 1'b0;
			end else if (ovf_a && tmr.en_a) begin
				flag_a <= 1'b1;
			end
			if (tmr.clr_b) begin
				flag_b <= 1'b0;
			end else if (ovf_b && tmr.en_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	assign status = {flag_b, flag_a};
	assign irq    = flag_a | flag_b;

endmodule

`default_nettype wire

// ==== hw/fm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        wr,
	input  logic [1:0]  addr,
	input  logic [7:0]  din,
	output logic        busy,
	output logic        irq,
	output logic [1:0]  status,
	output logic        slot_valid,
	output logic [2:0]  slot_ch,
	output logic [1:0]  slot_op,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output logic [2:0]  alg,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic        keyon
);

	logic clk_en;

	fm_upd_if upd_bus ();
	fm_tmr_if tmr_bus ();

	fm_mmr u_mmr (
		.clk    (clk),
		.rst    (rst),
		.wr     (wr),
		.addr   (addr),
		.din    (din),
		.busy   (busy),
		.clk_en (clk_en),
		.upd    (upd_bus.src),
		.tmr    (tmr_bus.ctl)
	);

	fm_reg_file u_reg (
		.clk        (clk),
		.rst        (rst),
		.clk_en     (clk_en),
		.upd        (upd_bus.dst),
		.slot_valid (slot_valid),
		.slot_ch    (slot_ch),
		.slot_op    (slot_op),
		.fnum       (fnum),
		.block      (block),
		.fb         (fb),
		.alg        (alg),
		.dt1        (dt1),
		.mul        (mul),
		.tl         (tl),
		.ks         (ks),
		.ar         (ar),
		.keyon      (keyon)
	);

	fm_timers u_tmr (
		.clk    (clk),
		.rst    (rst),
		.clk_en (clk_en),
		.tmr    (tmr_bus.tmr),
		.irq    (irq),
		.status (status)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running clock, 8 ns period
module tb_clk (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#4 clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== testbench/fm_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic clk_en,
	input wire logic busy,
	input wire logic valid,
	input wire logic done
);

	// divider tick never lasts two cycles
	clk_en_width: assert property (@(posedge clk) disable iff (rst) clk_en |=> !clk_en)
		else $error("clk_en high for more than one cycle");

	// request drops on the cycle after the register file takes it
	done_drops_valid: assert property (@(posedge clk) disable iff (rst) done |=> !valid)
		else $error("update request held past done");

	// request stays up until the register file takes it
	valid_hold: assert property (@(posedge clk) disable iff (rst) valid && !done |=> valid)
		else $error("update request dropped before done");

	busy_reset: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high after reset");

endmodule

bind fm_mmr fm_sva u_sva (
	.clk    (clk),
	.rst    (rst),
	.clk_en (clk_en),
	.busy   (busy),
	.valid  (upd.valid),
	.done   (upd.done)
);

`default_nettype wire

// ==== testbench/tb_fm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fm
	import fm_pkg::*;
();

	logic        clk;
	logic        rst;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic        busy;
	logic        irq;
	logic [1:0]  status;
	logic        slot_valid;
	logic [2:0]  slot_ch;
	logic [1:0]  slot_op;
	logic [10:0] fnum;
	logic [2:0]  block;
	logic [2:0]  fb;
	logic [2:0]  alg;
	logic [2:0]  dt1;
	logic [3:0]  mul;
	logic [6:0]  tl;
	logic [1:0]  ks;
	logic [4:0]  ar;
	logic        keyon;

	// reference model
	logic [2:0]  m_dt1 [NUM_SLOTS];
	logic [3:0]  m_mul [NUM_SLOTS];
	logic [6:0]  m_tl  [NUM_SLOTS];
	logic [1:0]  m_ks  [NUM_SLOTS];
	logic [4:0]  m_ar  [NUM_SLOTS];
	logic        m_kon [NUM_SLOTS];
	logic [10:0] m_fnum  [NUM_CH];
	logic [2:0]  m_block [NUM_CH];
	logic [2:0]  m_fb    [NUM_CH];
	logic [2:0]  m_alg   [NUM_CH];
	int          m_div;

	integer seed = 8;
	int     cyc = 0;
	int     errors = 0;
	int     test_errs = 0;
	int     tests = 0;
	longint wd_ns;

	tb_clk u_clk (.clk(clk));

	fm_top DUT (
		.clk(clk), .rst(rst), .wr(wr), .addr(addr), .din(din),
		.busy(busy), .irq(irq), .status(status),
		.slot_valid(slot_valid), .slot_ch(slot_ch), .slot_op(slot_op),
		.fnum(fnum), .block(block), .fb(fb), .alg(alg), .dt1(dt1),
		.mul(mul), .tl(tl), .ks(ks), .ar(ar), .keyon(keyon)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %s (%0d errors)", tests, name,
			(errors == test_errs) ? "ok" : "failed", errors - test_errs);
		test_errs = errors;
	endtask

	// register write rules of the chip, applied once busy falls
	task automatic apply_model(input logic [7:0] r, input logic bank, input logic [7:0] d);
		int c;
		int s;
		c = (bank ? 3 : 0) + r[1:0];
		s = c * 4 + r[3:2];
		if (r == ADDR_KEYON) begin
			if (d[1:0] != 2'd3) begin
				c = (d[2] ? 3 : 0) + d[1:0];
				for (int o = 0; o < NUM_OP; o++) begin
					m_kon[c * 4 + o] = d[4 + o];
				end
			end
		end else if (r == ADDR_DIV6) begin
			m_div = 6;
		end else if (r == ADDR_DIV3) begin
			m_div = 3;
		end else if (r == ADDR_DIV2) begin
			m_div = 2;
		end else if (r[1:0] == 2'd3) begin
			// no channel 3 in a bank
		end else if (r[7:4] == 4'h3) begin
			m_dt1[s] = d[6:4];
			m_mul[s] = d[3:0];
		end else if (r[7:4] == 4'h4) begin
			m_tl[s] = d[6:0];
		end else if (r[7:4] == 4'h5) begin
			m_ks[s] = d[7:6];
			m_ar[s] = d[4:0];
		end else if (r[7:2] == 6'h28) begin
			m_fnum[c][7:0] = d;
		end else if (r[7:2] == 6'h29) begin
			m_block[c] = d[5:3];
			m_fnum[c][10:8] = d[2:0];
		end else if (r[7:2] == 6'h2c) begin
			m_fb[c] = d[5:3];
			m_alg[c] = d[2:0];
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy === 1'b1 && n < NUM_SLOTS * 8 * 8) begin
			@(negedge clk);
			n++;
		end
		if (busy !== 1'b0) begin
			$display("busy never dropped after a data write");
			errors++;
		end
	endtask

	task automatic host_write(input logic [7:0] r, input logic bank, input logic [7:0] d);
		@(posedge clk);
		#1;
		wr = 1'b1;
		addr = {bank, 1'b0};
		din = r;
		@(posedge clk);
		#1;
		addr = {bank, 1'b1};
		din = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
		// every accepted data write raises busy on the next cycle
		check("busy", busy, 1'b1);
		wait_idle();
		apply_model(r, bank, d);
	endtask

	task automatic wait_slot();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (slot_valid !== 1'b1 && n < 64);
		if (slot_valid !== 1'b1) begin
			$display("slot stream stalled");
			errors++;
		end
	endtask

	// one full scan compared against the model
	task automatic compare_stream();
		int s;
		int c;
		for (int n = 0; n < NUM_SLOTS; n++) begin
			wait_slot();
			c = (slot_ch < 3'd6) ? slot_ch : 0;
			s = c * 4 + slot_op;
			check("slot_ch range", slot_ch < 3'd6, 1);
			check("dt1", dt1, m_dt1[s]);
			check("mul", mul, m_mul[s]);
			check("tl", tl, m_tl[s]);
			check("ks", ks, m_ks[s]);
			check("ar", ar, m_ar[s]);
			check("keyon", keyon, m_kon[s]);
			check("fnum", fnum, m_fnum[c]);
			check("block", block, m_block[c]);
			check("fb", fb, m_fb[c]);
			check("alg", alg, m_alg[c]);
		end
	endtask

	task automatic wait_status(input int idx, output int at);
		int n;
		n = 0;
		while (status[idx] !== 1'b1 && n < 20000) begin
			@(negedge clk);
			n++;
		end
		if (status[idx] !== 1'b1) begin
			$display("timer flag %0d never rose", idx);
			errors++;
		end
		at = cyc;
	endtask

	task automatic measure_ratio(input logic [7:0] r);
		int t0;
		int s0;
		host_write(r, 1'b0, 8'h00);
		// new ratio starts at the next wrap
		repeat (3) wait_slot();
		for (int i = 0; i < 4; i++) begin
			t0 = cyc;
			s0 = slot_ch * 4 + slot_op;
			wait_slot();
			check("slot_valid interval", cyc - t0, m_div);
			check("slot order", slot_ch * 4 + slot_op, (s0 + 1) % NUM_SLOTS);
		end
	endtask

	initial begin
		// worst case per write is a full scan at the slowest ratio
		wd_ns = 100 * NUM_SLOTS * 6 * 8 + 3 * 24 * 6 * 8 + 3 * 6 * 16 * 6 * 8;
		#(wd_ns);
		$display("watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [7:0] r;
		logic [7:0] d;
		logic       bk;
		int         a_val;
		int         b_val;
		int         t_load;
		int         t1;
		int         t2;
		int         p;

		rst = 1'b1;
		wr = 1'b0;
		addr = 2'b00;
		din = 8'h00;
		m_div = 6;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			m_dt1[i] = '0;
			m_mul[i] = '0;
			m_tl[i] = '0;
			m_ks[i] = '0;
			m_ar[i] = '0;
			m_kon[i] = 1'b0;
		end
		for (int c = 0; c < NUM_CH; c++) begin
			m_fnum[c] = '0;
			m_block[c] = '0;
			m_fb[c] = '0;
			m_alg[c] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// operator registers, channel 3 included
		for (int i = 0; i < 24; i++) begin
			case ({$random(seed)} % 3)
				0: r = ADDR_DT1_MUL;
				1: r = ADDR_TL;
				default: r = ADDR_KS_AR;
			endcase
			r = r | 8'(({$random(seed)} % 4) << 2) | 8'({$random(seed)} % 4);
			bk = 1'($random(seed));
			d = 8'($random(seed));
			host_write(r, bk, d);
		end
		compare_stream();
		finish_test("operator writes");

		// channel registers and key-on masks
		for (int i = 0; i < 24; i++) begin
			case ({$random(seed)} % 4)
				0: r = ADDR_FNUM_LO;
				1: r = ADDR_BLK_FHI;
				2: r = ADDR_FB_ALG;
				default: r = ADDR_KEYON;
			endcase
			d = 8'($random(seed));
			if (r != ADDR_KEYON) begin
				r = r | 8'({$random(seed)} % 4);
			end
			bk = 1'($random(seed));
			host_write(r, bk, d);
		end
		compare_stream();
		finish_test("channel and key-on writes");

		measure_ratio(ADDR_DIV3);
		measure_ratio(ADDR_DIV2);
		measure_ratio(ADDR_DIV6);
		finish_test("divider and scan order");

		// timer A, short periods keep the run brief
		a_val = 1000 + ({$random(seed)} % 16);
		p = 1024 - a_val;
		host_write(ADDR_TMRA_HI, 1'b0, 8'(a_val >> 2));
		host_write(ADDR_TMRA_LO, 1'b0, 8'(a_val & 3));
		host_write(ADDR_TMR_CTL, 1'b0, 8'h05);
		t_load = cyc;
		wait_status(0, t1);
		check("status[0] first delay in range",
			(t1 - t_load >= (p - 1) * m_div) && (t1 - t_load <= p * m_div + 1), 1);
		check("irq", irq, 1'b1);
		for (int i = 0; i < 2; i++) begin
			host_write(ADDR_TMR_CTL, 1'b0, 8'h15);
			check("status[0] after clear", status[0], 1'b0);
			check("irq after clear", irq, 1'b0);
			wait_status(0, t2);
			check("timer A period", t2 - t1, p * m_div);
			check("irq", irq, 1'b1);
			t1 = t2;
		end
		host_write(ADDR_TMR_CTL, 1'b0, 8'h10);
		check("irq after stop", irq, 1'b0);
		finish_test("timer A");

		// timer B at ratio 2
		host_write(ADDR_DIV2, 1'b0, 8'h00);
		repeat (3) wait_slot();
		b_val = 250 + ({$random(seed)} % 4);
		p = (256 - b_val) * 16;
		host_write(ADDR_TMRB, 1'b0, 8'(b_val));
		host_write(ADDR_TMR_CTL, 1'b0, 8'h0a);
		t_load = cyc;
		wait_status(1, t1);
		check("status[1] first delay in range",
			(t1 - t_load >= (p - 1) * m_div) && (t1 - t_load <= p * m_div + 1), 1);
		check("irq", irq, 1'b1);
		host_write(ADDR_TMR_CTL, 1'b0, 8'h2a);
		check("status[1] after clear", status[1], 1'b0);
		wait_status(1, t2);
		check("timer B period", t2 - t1, p * m_div);
		host_write(ADDR_TMR_CTL, 1'b0, 8'h20);
		finish_test("timer B");

		// second data write lands while busy is high
		r = ADDR_TL | 8'(({$random(seed)} % 4) << 2) | 8'({$random(seed)} % 3);
		d = 8'($random(seed));
		@(posedge clk);
		#1;
		wr = 1'b1;
		addr = 2'b00;
		din = r;
		@(posedge clk);
		#1;
		addr = 2'b01;
		din = d;
		@(posedge clk);
		#1;
		din = ~d;
		@(posedge clk);
		#1;
		wr = 1'b0;
		wait_idle();
		apply_model(r, 1'b0, d);
		compare_stream();
		finish_test("write while busy");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/fm_pkg.sv
hw/fm_upd_if.sv
hw/fm_tmr_if.sv
hw/fm_mmr.sv
hw/fm_reg_file.sv
hw/fm_timers.sv
hw/fm_top.sv
testbench/tb_clk.sv
testbench/fm_sva.sv
testbench/tb_fm.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_fm
FILELIST  ?= list.f
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
